/* hw/procPkg.sv */
package procPkg;

    // Data and address width of the core
    localparam int dataWidth = 8;

    // Fetch offset width, pc plus offset gives the ROM address
    localparam int offsetWidth = 2;

    // Program counter after reset, also the vector slot of line 0
    localparam logic [dataWidth-1:0] resetPc = 8'hFF;

    // Width of a thread index for a given number of interrupt lines
    function automatic int threadIndexWidth(int threads);
        return (threads > 1) ? $clog2(threads) : 1;
    endfunction

    //////////////////////////////
    // Instruction set

    // Low nibble of the first instruction byte
    typedef enum logic [3:0] {
        instrReadA   = 4'h0,
        instrReadB   = 4'h1,
        instrWriteA  = 4'h2,
        instrWriteB  = 4'h3,
        instrAluA    = 4'h4,
        instrAluB    = 4'h5,
        instrBranch  = 4'h6,
        instrGoto    = 4'h7,
        instrEnd     = 4'h8,
        instrCall    = 4'h9,
        instrReturn  = 4'hA
    } instrType_t;

    // High nibble of the first byte, used by ALU and branch instructions
    typedef enum logic [3:0] {
        aluAdd     = 4'h0,
        aluSub     = 4'h1,
        aluMul     = 4'h2,
        aluShl     = 4'h3,
        aluShr     = 4'h4,
        aluIncA    = 4'h5,
        aluIncB    = 4'h6,
        aluDecA    = 4'h7,
        aluDecB    = 4'h8,
        aluEqual   = 4'h9,
        aluGreater = 4'hA,
        aluLess    = 4'hB
    } aluOp_t;

    //////////////////////////////
    // Sequencer and block commands

    // Sequencer states, stSettle must stay last
    typedef enum logic [4:0] {
        stIdle, stVectorLoad, stVectorWait, stVectorFetch, stDecode,
        stReadSelect, stReadAddr, stReadStep, stReadCapture,
        stWriteStep, stWriteIssue, stAluStore, stBranchTest, stBranchTake,
        stJumpWait, stJumpLoad, stReturn, stSettle
    } fsmState_t;

    // pcOperand keeps the counter and points the fetch at the second byte
    typedef enum logic [2:0] {
        pcHold, pcStep1, pcStep2, pcLoadFetched, pcLoadVector, pcCall, pcReturn,
        pcOperand
    } pcCommand_t;

    typedef enum logic [3:0] {
        dpNone, dpReadA, dpReadB, dpSetReadAddr, dpCapture,
        dpWriteFromA, dpWriteFromB, dpAluToA, dpAluToB
    } dpCommand_t;

endpackage

/* hw/busPkg.sv */
package busPkg;

    // Data bus address and data widths
    localparam int busAddrWidth = 8;
    localparam int busDataWidth = 8;

    // Address parked on the bus when nothing is pending
    localparam logic [busAddrWidth-1:0] idleAddr = 8'hFF;

    // One registered bus access
    // we high for a single cycle marks a write
    typedef struct packed {
        logic [busAddrWidth-1:0] addr;
        logic [busDataWidth-1:0] data;
        logic                    we;
    } busRequest_t;

endpackage

/* hw/alu.sv */
`timescale 1ns/1ps

module alu (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic [procPkg::dataWidth-1:0] regA,
    input  logic [procPkg::dataWidth-1:0] regB,
    input  logic [procPkg::dataWidth-1:0] romData,
    output logic [procPkg::dataWidth-1:0] aluResult
);
    import procPkg::*;

    aluOp_t               aluOp;
    logic [dataWidth-1:0] aluNext;

    // Operation sits in the high nibble of the first byte
    assign aluOp = aluOp_t'(romData[7:4]);

    //////////////////////////////
    // Operation select

    always_comb begin
        case (aluOp)
            // Arithmetic
            aluAdd: aluNext = regA + regB;
            aluSub: aluNext = regA - regB;
            // Low byte of the product only
            aluMul: aluNext = regA * regB;
            // Shifts on A only
            aluShl: aluNext = regA << 1;
            aluShr: aluNext = regA >> 1;
            // Increment and decrement
            aluIncA: aluNext = regA + dataWidth'(1);
            aluIncB: aluNext = regB + dataWidth'(1);
            aluDecA: aluNext = regA - dataWidth'(1);
            aluDecB: aluNext = regB - dataWidth'(1);
            // Comparisons give 1 or 0, used by the branch test
            aluEqual: aluNext = (regA == regB) ? dataWidth'(1) : '0;
            aluGreater: aluNext = (regA > regB) ? dataWidth'(1) : '0;
            aluLess: aluNext = (regA < regB) ? dataWidth'(1) : '0;
            // Unused codes
            default: aluNext = '0;
        endcase
    end

    //////////////////////////////
    // Result register

    // Result valid one cycle after operands and opcode
    always_ff @(posedge CLK) begin
        if (RESET) begin
            aluResult <= '0;
        end else begin
            aluResult <= aluNext;
        end
    end

endmodule

/* hw/programCounter.sv */
`timescale 1ns/1ps

module programCounter #(
    parameter int numThreads = 2,
    localparam int indexWidth = procPkg::threadIndexWidth(numThreads)
) (
    input  logic                          CLK,
    input  logic                          RESET,
    input  procPkg::pcCommand_t           pcCmd,
    input  logic [indexWidth-1:0]         threadIndex,
    input  logic [procPkg::dataWidth-1:0] romData,
    output logic [procPkg::dataWidth-1:0] romAddr
);
    import procPkg::*;

    // Current instruction address
    logic [dataWidth-1:0]   pc;
    // Points the fetch at the second byte
    logic [offsetWidth-1:0] fetchOffset;
    // One level of call context
    logic [dataWidth-1:0]   callContext;

    // ROM address is the counter plus the offset
    assign romAddr = pc + dataWidth'(fetchOffset);

    //////////////////////////////
    // Counter update

    always_ff @(posedge CLK) begin
        if (RESET) begin
            pc <= resetPc;
            fetchOffset <= '0;
            callContext <= '0;
        end else begin
            // Offset lives for one cycle after the decode
            fetchOffset <= (pcCmd == pcOperand) ? offsetWidth'(1) : '0;

            case (pcCmd)
                pcStep1: pc <= pc + dataWidth'(1);
                pcStep2: pc <= pc + dataWidth'(2);
                // Jump target from the second byte
                pcLoadFetched: pc <= romData;
                // Vector slots count down from the top of ROM
                pcLoadVector: pc <= resetPc - dataWidth'(threadIndex);
                pcCall: begin
                    // Return lands after the two byte call
                    callContext <= pc + dataWidth'(2);
                    pc <= romData;
                end
                pcReturn: pc <= callContext;
                // Hold and operand fetch keep the counter
                default: pc <= pc;
            endcase
        end
    end

    //////////////////////////////
    // Checks

    // Decodes never fall on back to back cycles
    offsetPulse: assert property (
        @(posedge CLK) disable iff (RESET)
        (fetchOffset == offsetWidth'(1)) |=> (fetchOffset != offsetWidth'(1))
    );

endmodule

/* hw/dataPath.sv */
`timescale 1ns/1ps

module dataPath (
    input  logic                          CLK,
    input  logic                          RESET,
    input  procPkg::dpCommand_t           dpCmd,
    input  logic [procPkg::dataWidth-1:0] romData,
    input  logic [procPkg::dataWidth-1:0] busDataIn,
    input  logic [procPkg::dataWidth-1:0] aluResult,
    output logic [procPkg::dataWidth-1:0] regA,
    output logic [procPkg::dataWidth-1:0] regB,
    output busPkg::busRequest_t           busRequest
);
    import procPkg::*;
    import busPkg::*;

    // Destination of a pending read, 0 for A and 1 for B
    logic        regSelect;
    busRequest_t busNext;

    //////////////////////////////
    // Bus request

    always_comb begin
        // Park the bus unless a command drives it
        busNext = busRequest;
        busNext.addr = idleAddr;
        busNext.we = 1'b0;

        case (dpCmd)
            // Read address comes from the second byte
            dpSetReadAddr: busNext.addr = romData;
            dpWriteFromA: begin
                busNext.addr = romData;
                busNext.data = regA;
                busNext.we = 1'b1;
            end
            dpWriteFromB: begin
                busNext.addr = romData;
                busNext.data = regB;
                busNext.we = 1'b1;
            end
            default: busNext.we = 1'b0;
        endcase
    end

    //////////////////////////////
    // Registers

    always_ff @(posedge CLK) begin
        if (RESET) begin
            regA <= '0;
            regB <= '0;
            regSelect <= 1'b0;
            busRequest <= '{addr: idleAddr, data: '0, we: 1'b0};
        end else begin
            busRequest <= busNext;

            case (dpCmd)
                // Remember where the read data goes
                dpReadA: regSelect <= 1'b0;
                dpReadB: regSelect <= 1'b1;
                // Memory data arrives one cycle after the address
                dpCapture: begin
                    if (regSelect) begin
                        regB <= busDataIn;
                    end else begin
                        regA <= busDataIn;
                    end
                end
                dpAluToA: regA <= aluResult;
                dpAluToB: regB <= aluResult;
                default: regSelect <= regSelect;
            endcase
        end
    end

    //////////////////////////////
    // Checks

    // A write always resumes with a fetch, never a second write
    singleWrite: assert property (
        @(posedge CLK) disable iff (RESET)
        busRequest.we |=> !busRequest.we
    );

endmodule

/* hw/controlFsm.sv */
`timescale 1ns/1ps

module controlFsm #(
    parameter int numThreads = 2,
    localparam int indexWidth = procPkg::threadIndexWidth(numThreads)
) (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic [procPkg::dataWidth-1:0] romData,
    input  logic [procPkg::dataWidth-1:0] aluResult,
    input  logic [numThreads-1:0]         interruptRaise,
    output logic [numThreads-1:0]         interruptAck,
    output logic [indexWidth-1:0]         threadIndex,
    output procPkg::pcCommand_t           pcCmd,
    output procPkg::dpCommand_t           dpCmd
);
    import procPkg::*;

    fsmState_t             state;
    fsmState_t             stateNext;
    // Instruction latched at decode, the second byte replaces it on romData
    instrType_t            curInstr;
    instrType_t            fetchedInstr;
    logic [indexWidth-1:0] grantIndex;
    logic                  threadRequest;
    logic                  branchTaken;

    assign fetchedInstr = instrType_t'(romData[3:0]);
    assign threadRequest = |interruptRaise;
    // Comparison result from the first byte
    assign branchTaken = (aluResult != '0);

    // Fixed priority, lowest raised line wins
    always_comb begin
        grantIndex = '0;
        for (int i = numThreads - 1; i >= 0; i--) begin
            if (interruptRaise[i]) begin
                grantIndex = indexWidth'(i);
            end
        end
    end

    //////////////////////////////
    // Next state

    always_comb begin
        stateNext = state;
        case (state)
            stIdle: begin
                if (threadRequest) begin
                    stateNext = stVectorLoad;
                end
            end
            // Vector read from the top of ROM
            stVectorLoad: stateNext = stVectorWait;
            stVectorWait: stateNext = stVectorFetch;
            stVectorFetch: stateNext = stSettle;
            stDecode: begin
                case (fetchedInstr)
                    instrReadA, instrReadB: stateNext = stReadSelect;
                    instrWriteA, instrWriteB: stateNext = stWriteStep;
                    instrAluA, instrAluB: stateNext = stAluStore;
                    instrBranch: stateNext = stBranchTest;
                    instrGoto, instrCall: stateNext = stJumpWait;
                    instrReturn: stateNext = stReturn;
                    // End thread and undefined codes
                    default: stateNext = stIdle;
                endcase
            end
            // Read sequence
            stReadSelect: stateNext = stReadAddr;
            stReadAddr: stateNext = stReadStep;
            stReadStep: stateNext = stReadCapture;
            stReadCapture: stateNext = stDecode;
            // Write sequence
            stWriteStep: stateNext = stWriteIssue;
            stWriteIssue: stateNext = stDecode;
            stAluStore: stateNext = stSettle;
            stBranchTest: stateNext = branchTaken ? stBranchTake : stSettle;
            stBranchTake: stateNext = stSettle;
            // Goto and call share the jump
            stJumpWait: stateNext = stJumpLoad;
            stJumpLoad: stateNext = stSettle;
            stReturn: stateNext = stSettle;
            // New address needs a cycle before the ROM data is valid
            stSettle: stateNext = stDecode;
            default: stateNext = stIdle;
        endcase
    end

    //////////////////////////////
    // Block commands

    always_comb begin
        pcCmd = pcHold;
        dpCmd = dpNone;
        case (state)
            stVectorLoad: pcCmd = pcLoadVector;
            stVectorFetch: pcCmd = pcLoadFetched;
            stDecode: pcCmd = pcOperand;
            stReadSelect: dpCmd = (curInstr == instrReadB) ? dpReadB : dpReadA;
            stReadAddr: dpCmd = dpSetReadAddr;
            stReadStep: pcCmd = pcStep2;
            stReadCapture: dpCmd = dpCapture;
            stWriteStep: pcCmd = pcStep2;
            stWriteIssue: dpCmd = (curInstr == instrWriteB) ? dpWriteFromB : dpWriteFromA;
            stAluStore: begin
                pcCmd = pcStep1;
                dpCmd = (curInstr == instrAluB) ? dpAluToB : dpAluToA;
            end
            // Skip the target byte when not taken
            stBranchTest: pcCmd = branchTaken ? pcHold : pcStep2;
            stBranchTake: pcCmd = pcLoadFetched;
            stJumpLoad: pcCmd = (curInstr == instrCall) ? pcCall : pcLoadFetched;
            stReturn: pcCmd = pcReturn;
            default: pcCmd = pcHold;
        endcase
    end

    //////////////////////////////
    // State and interrupt registers

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state <= stIdle;
            curInstr <= instrEnd;
            threadIndex <= '0;
            interruptAck <= '0;
        end else begin
            state <= stateNext;
            // Ack is a one cycle pulse
            interruptAck <= '0;
            if (state == stIdle && threadRequest) begin
                threadIndex <= grantIndex;
                interruptAck <= numThreads'(1) << grantIndex;
            end
            if (state == stDecode) begin
                curInstr <= fetchedInstr;
            end
        end
    end

    //////////////////////////////
    // Checks

    // Single line acked, dropped on the next cycle
    ackPulse: assert property (
        @(posedge CLK) disable iff (RESET)
        (interruptAck != '0) |-> $onehot(interruptAck) ##1 (interruptAck == '0)
    );

    legalState: assert property (
        @(posedge CLK) disable iff (RESET)
        !$isunknown(state) && (state inside {[stIdle:stSettle]})
    );

endmodule

/* hw/processorTop.sv */
`timescale 1ns/1ps

module processorTop #(
    parameter int numThreads = 2,
    localparam int indexWidth = procPkg::threadIndexWidth(numThreads)
) (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic [procPkg::dataWidth-1:0] romData,
    input  logic [procPkg::dataWidth-1:0] busDataIn,
    input  logic [numThreads-1:0]         interruptRaise,
    output logic [procPkg::dataWidth-1:0] romAddr,
    output busPkg::busRequest_t           busRequest,
    output logic [numThreads-1:0]         interruptAck
);
    import procPkg::*;

    // Sequencer commands
    pcCommand_t            pcCmd;
    dpCommand_t            dpCmd;
    logic [indexWidth-1:0] threadIndex;
    // Operands and result
    logic [dataWidth-1:0]  aluResult;
    logic [dataWidth-1:0]  regA;
    logic [dataWidth-1:0]  regB;

    controlFsm #(.numThreads(numThreads)) controlFsm_i (
        .CLK(CLK), .RESET(RESET),
        .romData(romData), .aluResult(aluResult),
        .interruptRaise(interruptRaise), .interruptAck(interruptAck),
        .threadIndex(threadIndex), .pcCmd(pcCmd), .dpCmd(dpCmd)
    );

    programCounter #(.numThreads(numThreads)) programCounter_i (
        .CLK(CLK), .RESET(RESET),
        .pcCmd(pcCmd), .threadIndex(threadIndex),
        .romData(romData), .romAddr(romAddr)
    );

    // Registers and bus request
    dataPath dataPath_i (
        .CLK(CLK), .RESET(RESET), .dpCmd(dpCmd),
        .romData(romData), .busDataIn(busDataIn), .aluResult(aluResult),
        .regA(regA), .regB(regB), .busRequest(busRequest)
    );

    // Opcode nibble straight from ROM
    alu alu_i (
        .CLK(CLK), .RESET(RESET),
        .regA(regA), .regB(regB), .romData(romData), .aluResult(aluResult)
    );

endmodule

/* verification/memoryModel.sv */
`timescale 1ns/1ps

module memoryModel (
    input  logic                             CLK,
    input  logic [procPkg::dataWidth-1:0]    romAddr,
    input  busPkg::busRequest_t              busRequest,
    output logic [procPkg::dataWidth-1:0]    romData,
    output logic [busPkg::busDataWidth-1:0]  busDataIn
);
    import busPkg::*;

    // Program ROM, contents written by the testbench
    logic [7:0]              rom [256];
    // Data memory behind the bus
    logic [busDataWidth-1:0] dataMem [256];

    // Defined read data before the first clock edge
    initial begin
        romData = '0;
        busDataIn = '0;
    end

    //////////////////////////////
    // ROM port

    // Byte at the address of cycle n shows up in cycle n+1
    always @(posedge CLK) begin
        romData <= rom[romAddr];
    end

    //////////////////////////////
    // Data port

    always @(posedge CLK) begin
        if (busRequest.we) begin
            dataMem[busRequest.addr] <= busRequest.data;
        end
        // Same one cycle latency as the ROM
        busDataIn <= dataMem[busRequest.addr];
    end

endmodule

/* verification/processorTb.sv */
`timescale 1ns/1ps

module processorTb;
    import procPkg::*;
    import busPkg::*;

    localparam int numThreads = 2;
    localparam int resetCycles = 16;
    localparam int rowCycles = 400;
    // Cycles without write or ack that mark the thread as finished
    localparam int quietCycles = 50;
    localparam int numRows = 9;
    localparam int numProgs = 6;
    localparam logic [7:0] threadStart = 8'h10;
    localparam logic [7:0] addrOperandA = 8'h80;
    localparam logic [7:0] addrOperandB = 8'h81;

    // Raised lines, expected ack, operand order, program number
    // Operand order 0 free, 1 equal, 2 A above B, 3 A below B
    typedef struct packed {
        logic [1:0] lines;
        logic [1:0] expAck;
        logic [1:0] opOrder;
        logic [2:0] progId;
    } testRow_t;

    // code 0x0n is ALU op n on the operands, 0x10 operand A, 0x11 operand B
    // cond 0xFF always, 0x0n needs op n nonzero, 0x1n needs op n zero
    typedef struct packed {
        logic [7:0] addr;
        logic [7:0] code;
        logic [7:0] cond;
    } expWrite_t;

    logic                  CLK;
    logic                  RESET;
    logic [7:0]            romData;
    logic [7:0]            busDataIn;
    logic [numThreads-1:0] interruptRaise;
    logic [7:0]            romAddr;
    busRequest_t           busRequest;
    logic [numThreads-1:0] interruptAck;
    integer                seed = 32'h7a3d;
    // Every we cycle of the running row
    busRequest_t           writeLog [$];

    //////////////////////////////
    // Test table

    testRow_t testTable [numRows] = '{
        {2'b11, 2'b01, 2'd0, 3'd0}, {2'b10, 2'b10, 2'd0, 3'd0},
        {2'b01, 2'b01, 2'd0, 3'd1},
        {2'b01, 2'b01, 2'd1, 3'd2}, {2'b10, 2'b10, 2'd2, 3'd2}, {2'b01, 2'b01, 2'd3, 3'd2},
        {2'b01, 2'b01, 2'd0, 3'd3},
        {2'b10, 2'b10, 2'd0, 3'd4}, {2'b01, 2'b01, 2'd0, 3'd5}
    };

    int progLen [numProgs] = '{7, 85, 19, 16, 7, 7};
    int expCount [numProgs] = '{1, 12, 4, 2, 1, 1};

    // Programs stored back to back and loaded one at a time at threadStart
    logic [7:0] progPool [$] = '{
        // Read A, write it, end, dead write
        8'h00, 8'h80, 8'h02, 8'h90, 8'h08, 8'h02, 8'h9E,
        // Reload both, one ALU op, write the destination, two ops per line
        8'h00, 8'h80, 8'h01, 8'h81, 8'h04, 8'h02, 8'hA0, 8'h00, 8'h80, 8'h01, 8'h81, 8'h15, 8'h03, 8'hA1,
        8'h00, 8'h80, 8'h01, 8'h81, 8'h24, 8'h02, 8'hA2, 8'h00, 8'h80, 8'h01, 8'h81, 8'h35, 8'h03, 8'hA3,
        8'h00, 8'h80, 8'h01, 8'h81, 8'h44, 8'h02, 8'hA4, 8'h00, 8'h80, 8'h01, 8'h81, 8'h55, 8'h03, 8'hA5,
        8'h00, 8'h80, 8'h01, 8'h81, 8'h64, 8'h02, 8'hA6, 8'h00, 8'h80, 8'h01, 8'h81, 8'h75, 8'h03, 8'hA7,
        8'h00, 8'h80, 8'h01, 8'h81, 8'h84, 8'h02, 8'hA8, 8'h00, 8'h80, 8'h01, 8'h81, 8'h95, 8'h03, 8'hA9,
        8'h00, 8'h80, 8'h01, 8'h81, 8'hA4, 8'h02, 8'hAA, 8'h00, 8'h80, 8'h01, 8'h81, 8'hB5, 8'h03, 8'hAB,
        8'h08,
        // Each taken branch skips the write right after it
        8'h00, 8'h80, 8'h01, 8'h81, 8'h96, 8'h18, 8'h02, 8'h91, 8'hA6, 8'h1C,
        8'h02, 8'h92, 8'hB6, 8'h20, 8'h02, 8'h93, 8'h03, 8'h94, 8'h08,
        // Goto over a write, call 0x1D, subroutine after the end
        8'h00, 8'h80, 8'h01, 8'h81, 8'h07, 8'h18, 8'h02, 8'h9F,
        8'h09, 8'h1D, 8'h03, 8'h92, 8'h08, 8'h02, 8'h91, 8'h0A,
        // Undefined opcodes C and F stop the thread
        8'h00, 8'h80, 8'h02, 8'h93, 8'h0C, 8'h02, 8'h9E,
        8'h00, 8'h80, 8'h02, 8'h93, 8'hDF, 8'h02, 8'h9E
    };

    expWrite_t expPool [$] = '{
        {8'h90, 8'h10, 8'hFF},
        {8'hA0, 8'h00, 8'hFF}, {8'hA1, 8'h01, 8'hFF}, {8'hA2, 8'h02, 8'hFF}, {8'hA3, 8'h03, 8'hFF},
        {8'hA4, 8'h04, 8'hFF}, {8'hA5, 8'h05, 8'hFF}, {8'hA6, 8'h06, 8'hFF}, {8'hA7, 8'h07, 8'hFF},
        {8'hA8, 8'h08, 8'hFF}, {8'hA9, 8'h09, 8'hFF}, {8'hAA, 8'h0A, 8'hFF}, {8'hAB, 8'h0B, 8'hFF},
        {8'h91, 8'h10, 8'h19}, {8'h92, 8'h10, 8'h1A}, {8'h93, 8'h10, 8'h1B}, {8'h94, 8'h11, 8'hFF},
        {8'h91, 8'h10, 8'hFF}, {8'h92, 8'h11, 8'hFF},
        {8'h93, 8'h10, 8'hFF},
        {8'h93, 8'h10, 8'hFF}
    };

    processorTop #(.numThreads(numThreads)) processorTop_i (
        .CLK(CLK), .RESET(RESET),
        .romData(romData), .busDataIn(busDataIn), .interruptRaise(interruptRaise),
        .romAddr(romAddr), .busRequest(busRequest), .interruptAck(interruptAck)
    );

    memoryModel memories (
        .CLK(CLK), .romAddr(romAddr), .busRequest(busRequest),
        .romData(romData), .busDataIn(busDataIn)
    );

    //////////////////////////////
    // Reference rules and helpers

    // Result of ALU op on two operands
    function automatic logic [7:0] aluRule(input logic [3:0] op, input logic [7:0] a,
                                           input logic [7:0] b);
        logic [15:0] product;
        product = a * b;
        case (op)
            4'h0: return a + b;
            4'h1: return a - b;
            // Low byte of the product
            4'h2: return product[7:0];
            4'h3: return {a[6:0], 1'b0};
            4'h4: return {1'b0, a[7:1]};
            4'h5: return a + 8'd1;
            4'h6: return b + 8'd1;
            4'h7: return a - 8'd1;
            4'h8: return b - 8'd1;
            // Comparisons as 1 or 0
            4'h9: return (a == b) ? 8'd1 : 8'd0;
            4'hA: return (a > b) ? 8'd1 : 8'd0;
            4'hB: return (a < b) ? 8'd1 : 8'd0;
            default: return 8'd0;
        endcase
    endfunction

    function automatic logic [7:0] expectedValue(input logic [7:0] code, input logic [7:0] a,
                                                 input logic [7:0] b);
        if (code == 8'h10) begin
            return a;
        end else if (code == 8'h11) begin
            return b;
        end
        return aluRule(code[3:0], a, b);
    endfunction

    // Whether a write survives the branches around it
    function automatic bit conditionHolds(input logic [7:0] cond, input logic [7:0] a,
                                          input logic [7:0] b);
        if (cond == 8'hFF) begin
            return 1'b1;
        end else if (cond[4]) begin
            return aluRule(cond[3:0], a, b) == 8'd0;
        end
        return aluRule(cond[3:0], a, b) != 8'd0;
    endfunction

    task automatic reportError(input string msg);
        $display("** Error at time %0t: %s", $time, msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Stopping on first error");
    endtask

    task automatic fillMemories();
        logic [7:0] a;
        for (int i = 0; i < 256; i++) begin
            a = 8'(i);
            // Low nibble 8 makes a stray fetch end the thread
            memories.rom[i] = {a[7:4] ^ a[3:0], 4'h8};
            memories.dataMem[i] = a ^ 8'h5A;
        end
    endtask

    task automatic loadMemories(input testRow_t row, input logic [7:0] opA,
                                input logic [7:0] opB);
        int base;
        base = 0;
        for (int p = 0; p < row.progId; p++) begin
            base += progLen[p];
        end
        fillMemories();
        for (int i = 0; i < progLen[row.progId]; i++) begin
            memories.rom[threadStart + i] = progPool[base + i];
        end
        // Only the vector of the expected winner points at the program
        memories.rom[resetPc - (row.expAck[0] ? 8'd0 : 8'd1)] = threadStart;
        memories.dataMem[addrOperandA] = opA;
        memories.dataMem[addrOperandB] = opB;
    endtask

    task automatic checkWrites(input int rowIdx, input int progId, input logic [7:0] opA,
                               input logic [7:0] opB);
        int          base;
        expWrite_t   entry;
        busRequest_t one;
        busRequest_t expected [$];
        base = 0;
        for (int p = 0; p < progId; p++) begin
            base += expCount[p];
        end
        for (int i = 0; i < expCount[progId]; i++) begin
            entry = expPool[base + i];
            if (conditionHolds(entry.cond, opA, opB)) begin
                one.addr = entry.addr;
                one.data = expectedValue(entry.code, opA, opB);
                one.we = 1'b1;
                expected.push_back(one);
            end
        end
        assert (writeLog.size() == expected.size())
            else reportError($sformatf("row %0d: %0d writes, expected %0d",
                                       rowIdx, writeLog.size(), expected.size()));
        for (int i = 0; i < expected.size(); i++) begin
            assert (writeLog[i].addr == expected[i].addr && writeLog[i].data == expected[i].data)
                else reportError($sformatf("row %0d write %0d: %02h at %02h, expected %02h at %02h",
                                           rowIdx, i, writeLog[i].data, writeLog[i].addr,
                                           expected[i].data, expected[i].addr));
        end
    endtask

    // Raise, check the ack, log writes until the core has gone quiet
    task automatic runRow(input int rowIdx);
        testRow_t   row;
        logic [7:0] opA;
        logic [7:0] opB;
        logic [7:0] swap;
        int         quiet;
        row = testTable[rowIdx];
        opA = 8'($random(seed));
        opB = 8'($random(seed));
        if (row.opOrder == 2'd1) begin
            opB = opA;
        end else if (row.opOrder != 2'd0) begin
            // Distinct operands in the order the row asks for
            if (opA == opB) begin
                opB = opA ^ 8'h01;
            end
            if ((opA > opB) != (row.opOrder == 2'd2)) begin
                swap = opA;
                opA = opB;
                opB = swap;
            end
        end
        loadMemories(row, opA, opB);
        writeLog.delete();
        @(posedge CLK);
        interruptRaise <= row.lines;
        while (interruptAck == '0) begin
            @(negedge CLK);
        end
        assert (interruptAck == row.expAck)
            else reportError($sformatf("row %0d: ack %b, expected %b",
                                       rowIdx, interruptAck, row.expAck));
        @(posedge CLK);
        interruptRaise <= '0;
        quiet = 0;
        while (quiet < quietCycles) begin
            @(negedge CLK);
            // Ack lasts one cycle and nothing is raised now
            assert (interruptAck == '0)
                else reportError($sformatf("row %0d: unexpected ack %b", rowIdx, interruptAck));
            if (busRequest.we) begin
                writeLog.push_back(busRequest);
                quiet = 0;
            end else begin
                quiet++;
            end
        end
        checkWrites(rowIdx, row.progId, opA, opB);
    endtask

    //////////////////////////////
    // Clock, watchdog and main sequence

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    initial begin
        repeat (resetCycles + rowCycles * numRows) @(posedge CLK);
        $display("Run timed out: the test table did not finish within %0d cycles",
                 resetCycles + rowCycles * numRows);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        int poolBytes;
        int poolWrites;
        RESET = 1'b1;
        interruptRaise = '0;
        poolBytes = 0;
        poolWrites = 0;
        for (int p = 0; p < numProgs; p++) begin
            poolBytes += progLen[p];
            poolWrites += expCount[p];
        end
        assert (poolBytes == progPool.size() && poolWrites == expPool.size())
            else reportError("program lengths or write counts do not match the table pools");
        fillMemories();
        repeat (resetCycles) @(posedge CLK);
        RESET <= 1'b0;
        @(negedge CLK);
        // Idle state right after reset
        assert (busRequest.we == 1'b0 && interruptAck == '0)
            else reportError($sformatf("after reset we %b ack %b", busRequest.we, interruptAck));
        assert (busRequest.addr == idleAddr && romAddr == resetPc)
            else reportError($sformatf("after reset bus addr %02h rom addr %02h",
                                       busRequest.addr, romAddr));
        for (int r = 0; r < numRows; r++) begin
            runRow(r);
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* files.f */
hw/procPkg.sv
hw/busPkg.sv
hw/alu.sv
hw/programCounter.sv
hw/dataPath.sv
hw/controlFsm.sv
hw/processorTop.sv
verification/memoryModel.sv
verification/processorTb.sv
